//--- fp32_mul.f
+incdir+.
fp32_mul_pkg.sv
fp32_operand_unpack.sv
fp32_sig_multiplier.sv
fp32_round_pack.sv
fp32_mul_ctrl.sv
fp32_mul.sv
fp32_mul_tb_clkgen.sv
fp32_mul_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fp32_mul testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f fp32_mul.f \
    --top-module fp32_mul_tb \
    -o sim_fp32_mul

./obj_dir/sim_fp32_mul | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "run_sim: testbench reported failure"
    exit 1
fi

if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "run_sim: no verdict found in $LOG"
    exit 1
fi

echo "run_sim: testbench passed"

//--- fp32_mul_tb.sv
`timescale 1ns/1ps

module fp32_mul_tb;

    localparam int          NUM_ENTRIES  = 20;
    localparam int          DONE_LATENCY = 27;             // cycles from start edge to done
    localparam int          BUSY_START   = 4;              // cycle of the ignored second start
    localparam int          IDLE_WATCH   = 32;             // longer than one full operation
    localparam int          CYCLE_LIMIT  = 40 * NUM_ENTRIES + 100;
    localparam logic [31:0] ALT_OPERAND  = 32'h4049_0FDB;  // pi, only seen while busy

    logic        clk;
    logic        rst_n;
    logic [31:0] a;
    logic [31:0] b;
    logic        start;
    logic        busy;
    logic        done;
    logic        nan;
    logic        inf;
    logic        ovf;
    logic        unf;
    logic [31:0] product;

    logic [99:0] vec_table [0:NUM_ENTRIES-1];   // {a, b, product, nan, inf, ovf, unf}
    int          cycle_cnt     = 0;
    int          checks        = 0;
    int          value_errors  = 0;
    int          timing_errors = 0;
    int          cur_entry     = -1;            // -1 while checking reset values

    fp32_mul_tb_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fp32_mul i_fp32_mul (
        .clk         (clk),
        .rst_n       (rst_n),
        .a_i         (a),
        .b_i         (b),
        .start_i     (start),
        .busy_o      (busy),
        .done_o      (done),
        .nan_o       (nan),
        .infinity_o  (inf),
        .overflow_o  (ovf),
        .underflow_o (unf),
        .product_o   (product)
    );

    task automatic fill_table();
        vec_table[0]  = {32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000, 4'b0000};  // 1.5 * 2
        vec_table[1]  = {32'hC000_0000, 32'h4040_0000, 32'hC0C0_0000, 4'b0000};  // -2 * 3
        vec_table[2]  = {32'h3F80_0000, 32'h3F80_0000, 32'h3F80_0000, 4'b0000};  // 1 * 1
        vec_table[3]  = {32'hC040_0000, 32'hC000_0000, 32'h40C0_0000, 4'b0000};  // -3 * -2
        vec_table[4]  = {32'h3F80_0001, 32'h3F80_0001, 32'h3F80_0002, 4'b0000};  // 2^-46 dropped
        vec_table[5]  = {32'h3FFF_FFFF, 32'h3FFF_FFFF, 32'h407F_FFFE, 4'b0000};  // product >= 2
        vec_table[6]  = {32'h7F80_0001, 32'h3F80_0000, 32'h7FC0_0000, 4'b1000};  // snan * 1
        vec_table[7]  = {32'h3F80_0000, 32'hFFC0_0000, 32'h7FC0_0000, 4'b1000};  // 1 * -qnan
        vec_table[8]  = {32'h7F80_0000, 32'h0000_0000, 32'h7FC0_0000, 4'b1000};  // inf * 0
        vec_table[9]  = {32'h7F80_0000, 32'hC000_0000, 32'hFF80_0000, 4'b0100};  // inf * -2
        vec_table[10] = {32'h0000_0000, 32'h40A0_0000, 32'h0000_0000, 4'b0000};  // 0 * 5
        vec_table[11] = {32'h8000_0000, 32'h4000_0000, 32'h8000_0000, 4'b0000};  // -0 * 2
        vec_table[12] = {32'h0000_0001, 32'h4000_0000, 32'h0000_0000, 4'b0000};  // subnormal flushed
        vec_table[13] = {32'h7F00_0000, 32'h7F00_0000, 32'h7F80_0000, 4'b0010};  // 2^127 squared
        vec_table[14] = {32'h0080_0000, 32'h0080_0000, 32'h0000_0000, 4'b0001};  // 2^-126 squared
        vec_table[15] = {32'h3F80_0001, 32'h3FC0_0001, 32'h3FC0_0003, 4'b0000};  // sticky rounds up
        vec_table[16] = {32'h3FC0_0001, 32'h3FC0_0001, 32'h4010_0002, 4'b0000};  // round up above 2
        vec_table[17] = {32'h3F80_0001, 32'h4040_0000, 32'h4040_0002, 4'b0000};  // odd lsb tie up
        vec_table[18] = {32'h3F80_0003, 32'h3FC0_0000, 32'h3FC0_0004, 4'b0000};  // even lsb tie kept
        vec_table[19] = {32'h3F80_0001, 32'h3FFF_FFFE, 32'h4000_0000, 4'b0000};  // carry into 2.0
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            value_errors++;
            $display("[ERROR] %0t: entry %0d %s is %08h, expected %08h",
                     $time, cur_entry, what, got, want);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic want);
        checks++;
        assert (got === want) else begin
            value_errors++;
            $display("[ERROR] %0t: entry %0d %s is %b, expected %b",
                     $time, cur_entry, what, got, want);
        end
    endtask

    task automatic check_timing(input string what, input int got, input int want);
        checks++;
        assert (got == want) else begin
            timing_errors++;
            $display("[ERROR] %0t: entry %0d %s is %0d, expected %0d",
                     $time, cur_entry, what, got, want);
        end
    endtask

    // one table entry, with a second start thrown in while busy
    task automatic run_entry(input int idx);
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] want_prod;
        logic [3:0]  want_flags;
        int          lat;
        logic        seen;
        {op_a, op_b, want_prod, want_flags} = vec_table[idx];
        cur_entry = idx;
        lat       = 0;
        seen      = 1'b0;
        @(posedge clk);
        a     <= op_a;
        b     <= op_b;
        start <= 1'b1;
        while (!seen) begin
            @(posedge clk);                    // first pass is the sampling edge
            if (lat == BUSY_START) begin
                start <= 1'b1;                 // must be ignored
                a     <= ALT_OPERAND;
                b     <= ALT_OPERAND;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            lat = lat + 1;
            if (done === 1'b1) begin
                seen = 1'b1;
            end else begin
                checks++;
                assert (busy === 1'b1) else begin
                    timing_errors++;
                    $display("[ERROR] %0t: entry %0d busy_o low in cycle %0d before done_o",
                             $time, idx, lat);
                end
            end
        end
        check_timing("done_o latency", lat, DONE_LATENCY);
        check_word("product_o", product, want_prod);
        check_bit("nan_o", nan, want_flags[3]);
        check_bit("infinity_o", inf, want_flags[2]);
        check_bit("overflow_o", ovf, want_flags[1]);
        check_bit("underflow_o", unf, want_flags[0]);
        @(negedge clk);
        check_bit("done_o one cycle later", done, 1'b0);   // single-cycle pulse
    endtask

    // no late done from the ignored start
    task automatic watch_idle(input int cycles);
        int n;
        n = 0;
        while (n < cycles) begin
            @(negedge clk);
            check_bit("done_o while idle", done, 1'b0);
            check_bit("busy_o while idle", busy, 1'b0);
            n++;
        end
    endtask

    // hang guard, limit scales with the table
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, done_o never came for entry %0d",
                     CYCLE_LIMIT, cur_entry);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        a     = '0;
        b     = '0;
        start = 1'b0;
        $timeformat(-9, 0, " ns", 0);
        fill_table();
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_word("product_o after reset", product, 32'h0);
        check_bit("done_o after reset", done, 1'b0);
        check_bit("busy_o after reset", busy, 1'b0);
        check_bit("nan_o after reset", nan, 1'b0);
        check_bit("infinity_o after reset", inf, 1'b0);
        check_bit("overflow_o after reset", ovf, 1'b0);
        check_bit("underflow_o after reset", unf, 1'b0);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        watch_idle(IDLE_WATCH);
        $display("checks %0d, value errors %0d, timing errors %0d",
                 checks, value_errors, timing_errors);
        if (value_errors + timing_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- fp32_mul_tb_clkgen.sv
`timescale 1ns/1ps

module fp32_mul_tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 20;      // 40 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;                    // reset held from time zero
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);                  // release away from the active edge
        rst_n_o = 1'b1;
    end

endmodule

//--- fp32_mul.sv
`timescale 1ns/1ps

module fp32_mul import fp32_mul_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  fp32_t a_i,
    input  fp32_t b_i,
    input  logic  start_i,
    output logic  busy_o,
    output logic  done_o,
    output logic  nan_o,
    output logic  infinity_o,
    output logic  overflow_o,
    output logic  underflow_o,
    output fp32_t product_o
);

    logic      load;
    logic      mul_start;
    logic      mul_done;
    logic      pack;
    logic      sign_a;
    logic      sign_b;
    exp_t      exp_a;
    exp_t      exp_b;
    sig_t      sig_a;
    sig_t      sig_b;
    logic      zero_a;
    logic      zero_b;
    logic      inf_a;
    logic      inf_b;
    logic      nan_a;
    logic      nan_b;
    sig_prod_t sig_prod;

    fp32_mul_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .mul_done_i  (mul_done),
        .load_o      (load),
        .mul_start_o (mul_start),
        .pack_o      (pack),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    fp32_operand_unpack u_unpack_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_i    (load),
        .op_i      (a_i),
        .sign_o    (sign_a),
        .exp_o     (exp_a),
        .sig_o     (sig_a),
        .is_zero_o (zero_a),
        .is_inf_o  (inf_a),
        .is_nan_o  (nan_a)
    );

    fp32_operand_unpack u_unpack_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_i    (load),
        .op_i      (b_i),
        .sign_o    (sign_b),
        .exp_o     (exp_b),
        .sig_o     (sig_b),
        .is_zero_o (zero_b),
        .is_inf_o  (inf_b),
        .is_nan_o  (nan_b)
    );

    fp32_sig_multiplier u_sig_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (mul_start),
        .sig_a_i (sig_a),
        .sig_b_i (sig_b),
        .prod_o  (sig_prod),
        .done_o  (mul_done)
    );

    fp32_round_pack u_round_pack (
        .clk         (clk),
        .rst_n       (rst_n),
        .pack_i      (pack),
        .sign_a_i    (sign_a),
        .exp_a_i     (exp_a),
        .is_zero_a_i (zero_a),
        .is_inf_a_i  (inf_a),
        .is_nan_a_i  (nan_a),
        .sign_b_i    (sign_b),
        .exp_b_i     (exp_b),
        .is_zero_b_i (zero_b),
        .is_inf_b_i  (inf_b),
        .is_nan_b_i  (nan_b),
        .prod_i      (sig_prod),
        .product_o   (product_o),
        .nan_o       (nan_o),
        .infinity_o  (infinity_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o)
    );

endmodule

//--- fp32_mul_ctrl.sv
`timescale 1ns/1ps

module fp32_mul_ctrl import fp32_mul_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start_i,                 // sampled in ST_IDLE only
    input  logic mul_done_i,              // multiplier on its last step
    output logic load_o,                  // operand capture
    output logic mul_start_o,             // first cycle of ST_MULT
    output logic pack_o,                  // result capture
    output logic busy_o,
    output logic done_o                   // one cycle, outputs valid
);

    mul_state_t state_q;
    mul_state_t state_d;
    logic       mul_start_q;
    logic       done_q;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i) begin
                    state_d = ST_LOAD;
                end
            end
            ST_LOAD: begin
                state_d = ST_MULT;
            end
            ST_MULT: begin
                if (mul_done_i) begin
                    state_d = ST_PACK;    // last step completes on this edge
                end
            end
            ST_PACK: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            mul_start_q <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            state_q     <= state_d;
            mul_start_q <= load_o;        // LOAD always moves to MULT, so entry pulse
            done_q      <= pack_o;        // lines up with registered product
        end
    end

    assign load_o      = (state_q == ST_LOAD);
    assign mul_start_o = mul_start_q;
    assign pack_o      = (state_q == ST_PACK);
    assign busy_o      = (state_q != ST_IDLE);   // start_i ignored while high
    assign done_o      = done_q;

endmodule

//--- fp32_round_pack.sv
`timescale 1ns/1ps
`include "fp32_mul_defines.svh"

module fp32_round_pack import fp32_mul_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pack_i,             // result register enable
    input  logic      sign_a_i,
    input  exp_t      exp_a_i,
    input  logic      is_zero_a_i,
    input  logic      is_inf_a_i,
    input  logic      is_nan_a_i,
    input  logic      sign_b_i,
    input  exp_t      exp_b_i,
    input  logic      is_zero_b_i,
    input  logic      is_inf_b_i,
    input  logic      is_nan_b_i,
    input  sig_prod_t prod_i,             // 1.xx * 1.xx, in [1,4)
    output fp32_t     product_o,
    output logic      nan_o,
    output logic      infinity_o,
    output logic      overflow_o,
    output logic      underflow_o
);

    localparam int        PROD_MSB  = 2 * `FP_FRAC_W + 1;   // bit 47
    localparam exp_wide_t BIAS      = exp_wide_t'(`FP_BIAS);
    localparam exp_wide_t EXP_LIMIT = exp_wide_t'(`FP_EXP_MAX);
    localparam exp_wide_t EXP_ZERO  = exp_wide_t'(0);
    localparam exp_wide_t EXP_ONE   = exp_wide_t'(1);

    logic                  sign_res;
    exp_wide_t             exp_sum;       // e_a + e_b - bias
    exp_wide_t             exp_norm;
    exp_wide_t             exp_rnd;
    logic [`FP_FRAC_W-1:0] frac_trunc;
    logic                  guard_bit;
    logic                  sticky_bit;
    logic                  round_up;
    logic [`FP_FRAC_W:0]   frac_rnd;      // msb is the rounding carry
    logic                  nan_case;
    logic                  inf_case;
    logic                  zero_case;
    logic                  ovf_case;
    logic                  unf_case;
    fp32_t                 result;
    logic                  nan_d;
    logic                  inf_d;
    logic                  ovf_d;
    logic                  unf_d;

    assign sign_res = sign_a_i ^ sign_b_i;
    assign exp_sum  = exp_wide_t'({2'b00, exp_a_i}) + exp_wide_t'({2'b00, exp_b_i}) - BIAS;

    // normalize, a product in [2,4) shifts right by one
    always_comb begin
        if (prod_i[PROD_MSB]) begin
            frac_trunc = prod_i[PROD_MSB-1 -: `FP_FRAC_W];
            guard_bit  = prod_i[PROD_MSB-1-`FP_FRAC_W];
            sticky_bit = |prod_i[PROD_MSB-2-`FP_FRAC_W:0];
            exp_norm   = exp_sum + EXP_ONE;
        end else begin
            frac_trunc = prod_i[PROD_MSB-2 -: `FP_FRAC_W];
            guard_bit  = prod_i[PROD_MSB-2-`FP_FRAC_W];
            sticky_bit = |prod_i[PROD_MSB-3-`FP_FRAC_W:0];
            exp_norm   = exp_sum;
        end
    end

    // nearest-even, a tie rounds up only when lsb is odd
    assign round_up = guard_bit & (sticky_bit | frac_trunc[0]);
    assign frac_rnd = {1'b0, frac_trunc} + {{`FP_FRAC_W{1'b0}}, round_up};
    // carry out means 1.111..1 became 10.000..0, fraction already zero
    assign exp_rnd  = exp_norm + exp_wide_t'({{(`FP_EXP_W+1){1'b0}}, frac_rnd[`FP_FRAC_W]});

    assign nan_case  = is_nan_a_i | is_nan_b_i | (is_inf_a_i & is_zero_b_i) |
                       (is_inf_b_i & is_zero_a_i);          // inf * 0 is invalid
    assign inf_case  = is_inf_a_i | is_inf_b_i;
    assign zero_case = is_zero_a_i | is_zero_b_i;
    assign ovf_case  = (exp_rnd >= EXP_LIMIT);              // signed compare
    assign unf_case  = (exp_rnd <= EXP_ZERO);               // no subnormal results

    // result select, first match wins
    always_comb begin
        result = {sign_res, exp_rnd[`FP_EXP_W-1:0], frac_rnd[`FP_FRAC_W-1:0]};
        nan_d  = 1'b0;
        inf_d  = 1'b0;
        ovf_d  = 1'b0;
        unf_d  = 1'b0;
        if (nan_case) begin
            result = `FP_QNAN;
            nan_d  = 1'b1;
        end else if (inf_case) begin
            result = {sign_res, {`FP_EXP_W{1'b1}}, {`FP_FRAC_W{1'b0}}};
            inf_d  = 1'b1;
        end else if (zero_case) begin
            result = {sign_res, {(`FP_EXP_W+`FP_FRAC_W){1'b0}}};   // exact, no flag
        end else if (ovf_case) begin
            result = {sign_res, {`FP_EXP_W{1'b1}}, {`FP_FRAC_W{1'b0}}};
            ovf_d  = 1'b1;
        end else if (unf_case) begin
            result = {sign_res, {(`FP_EXP_W+`FP_FRAC_W){1'b0}}};
            unf_d  = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product_o   <= '0;
            nan_o       <= 1'b0;
            infinity_o  <= 1'b0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else if (pack_i) begin        // hold until next pack
            product_o   <= result;
            nan_o       <= nan_d;
            infinity_o  <= inf_d;
            overflow_o  <= ovf_d;
            underflow_o <= unf_d;
        end
    end

endmodule

//--- fp32_sig_multiplier.sv
`timescale 1ns/1ps
`include "fp32_mul_defines.svh"

module fp32_sig_multiplier import fp32_mul_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,            // one-cycle strobe, also does step 1
    input  sig_t      sig_a_i,            // multiplicand
    input  sig_t      sig_b_i,            // multiplier
    output sig_prod_t prod_o,
    output logic      done_o              // high during the final step
);

    localparam step_cnt_t LAST_STEP = step_cnt_t'(`FP_MUL_STEPS - 1);
    localparam int        SIG_W     = `FP_FRAC_W + 1;

    sig_prod_t acc_q;                     // partial product
    sig_prod_t mcand_q;                   // multiplicand, shifts left each step
    sig_t      mplier_q;                  // multiplier, shifts right each step
    step_cnt_t step_q;                    // steps already done
    logic      run_q;

    sig_prod_t acc_src;
    sig_prod_t mcand_src;
    sig_t      mplier_src;
    sig_prod_t acc_next;

    // on start the step works straight off the inputs with a cleared accumulator,
    // so 24 edges of ST_MULT give 24 steps
    always_comb begin
        if (start_i) begin
            acc_src    = '0;
            mcand_src  = {{SIG_W{1'b0}}, sig_a_i};
            mplier_src = sig_b_i;
        end else begin
            acc_src    = acc_q;
            mcand_src  = mcand_q;
            mplier_src = mplier_q;
        end
    end

    assign acc_next = acc_src + (mplier_src[0] ? mcand_src : '0);  // add when lsb set

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            step_q <= '0;
        end else if (start_i) begin
            run_q  <= 1'b1;
            step_q <= step_cnt_t'(1);     // first step taken on the start edge
        end else if (run_q) begin
            step_q <= step_q + step_cnt_t'(1);
            if (step_q == LAST_STEP) begin
                run_q <= 1'b0;            // final step on this edge
            end
        end
    end

    // datapath, only meaningful after a start
    always_ff @(posedge clk) begin
        if (start_i || run_q) begin
            acc_q    <= acc_next;
            mcand_q  <= mcand_src << 1;
            mplier_q <= mplier_src >> 1;
        end
    end

    assign prod_o = acc_q;                // held once run_q drops
    assign done_o = run_q && (step_q == LAST_STEP);  // product final after this edge

endmodule

//--- fp32_operand_unpack.sv
`timescale 1ns/1ps
`include "fp32_mul_defines.svh"

module fp32_operand_unpack import fp32_mul_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load_i,                 // capture strobe from ctrl
    input  fp32_t op_i,
    output logic  sign_o,
    output exp_t  exp_o,
    output sig_t  sig_o,                  // hidden bit always set
    output logic  is_zero_o,              // zero or subnormal
    output logic  is_inf_o,
    output logic  is_nan_o
);

    fp32_t                 op_q;          // operand held for the whole operation
    logic [`FP_FRAC_W-1:0] frac;
    logic                  exp_all_ones;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= '0;
        end else if (load_i) begin
            op_q <= op_i;                 // top-level a_i/b_i only sampled here
        end
    end

    // field split
    assign sign_o = op_q[`FP_EXP_W+`FP_FRAC_W];
    assign exp_o  = op_q[`FP_FRAC_W +: `FP_EXP_W];
    assign frac   = op_q[`FP_FRAC_W-1:0];
    assign sig_o  = {1'b1, frac};         // meaningless for zero class, pack ignores it

    assign exp_all_ones = (exp_o == exp_t'(`FP_EXP_MAX));

    // classification, subnormals land in the zero class (flush)
    assign is_zero_o = (exp_o == '0);
    assign is_inf_o  = exp_all_ones & (frac == '0);
    assign is_nan_o  = exp_all_ones & (frac != '0);  // any payload, quiet or signalling

endmodule

//--- fp32_mul_pkg.sv
`include "fp32_mul_defines.svh"

package fp32_mul_pkg;

    typedef logic [`FP_EXP_W+`FP_FRAC_W:0] fp32_t;       // sign, exponent, fraction
    typedef logic [`FP_EXP_W-1:0]          exp_t;        // biased exponent field
    typedef logic [`FP_FRAC_W:0]           sig_t;        // 1.fraction
    typedef logic [2*`FP_FRAC_W+1:0]       sig_prod_t;   // full 24x24 product

    // two spare bits cover e_a + e_b - bias and both increments, sign included
    typedef logic signed [`FP_EXP_W+1:0]   exp_wide_t;

    typedef logic [$clog2(`FP_MUL_STEPS)-1:0] step_cnt_t;  // counts 0..24

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,                   // waiting for start
        ST_LOAD = 2'd1,                   // operands captured
        ST_MULT = 2'd2,                   // shift-add running
        ST_PACK = 2'd3                    // round and register result
    } mul_state_t;

endpackage

//--- fp32_mul_defines.svh
`ifndef FP32_MUL_DEFINES_SVH
`define FP32_MUL_DEFINES_SVH

// binary32 field layout
`define FP_EXP_W      8                 // biased exponent bits
`define FP_FRAC_W     23                // stored fraction bits, hidden bit not counted
`define FP_BIAS       127               // exponent bias
`define FP_EXP_MAX    255               // all-ones exponent, inf and nan

// iterative significand multiply, one multiplier bit per clock
`define FP_MUL_STEPS  24

// quiet nan returned for every invalid result, sign clear
`define FP_QNAN       32'h7FC0_0000

`endif
